// ==== common/ahb_bridge_pkg.sv ====
/*
 * AXI4 to AHB-Lite bridge shared definitions
 * Bus widths, response and transfer encodings, channel structs
 * and the strobe decoding used to split partial writes
 */
package ahb_bridge_pkg;

   // ********************
   // Widths and encodings
   // ********************
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   localparam logic [2:0] size_byte  = 3'd0;
   localparam logic [2:0] size_half  = 3'd1;
   localparam logic [2:0] size_word  = 3'd2;
   localparam logic [2:0] size_dword = 3'd3;

   // ********************
   // Channel structs
   // ********************
   typedef struct packed {
      logic [7:0]        id;      // Upper bits zero above ID_W
      logic [addr_w-1:0] addr;
      logic [2:0]        size;
      logic [2:0]        prot;
   } axi_aw_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [7:0]        tag;
      logic              write;
      logic [addr_w-1:0] addr;
      logic [2:0]        size;
      logic [2:0]        prot;
      logic [strb_w-1:0] byteen;
      logic [data_w-1:0] wdata;
   } bridge_cmd_t;

   typedef struct packed {
      logic [7:0]        tag;
      logic              write;
      logic              error;
      logic [data_w-1:0] rdata;
   } bridge_rsp_t;

   typedef struct packed {
      logic [addr_w-1:0] haddr;
      logic [2:0]        hsize;
      logic [1:0]        htrans;
      logic              hwrite;
      logic [3:0]        hprot;
   } ahb_req_t;

   // ********************
   // Strobe decoding
   // ********************

   // Lowest set strobe bit at or above start
   function automatic logic [2:0] next_byte_ptr(logic [strb_w-1:0] strb, logic [2:0] start);
      logic [2:0] ptr;
      ptr = start;
      for (int i = strb_w - 1; i >= 0; i--) begin
         if (strb[i] && (3'(i) >= start)) ptr = 3'(i);
      end
      return ptr;
   endfunction

   function automatic logic [2:0] strb_to_size(logic [strb_w-1:0] strb);
      case ($countones(strb))
         2:       return size_half;
         4:       return size_word;
         8:       return size_dword;
         default: return size_byte;
      endcase
   endfunction

   function automatic logic [2:0] strb_to_offset(logic [strb_w-1:0] strb);
      return next_byte_ptr(strb, 3'd0);
   endfunction

   // One contiguous group, sized by its bit count and aligned to it
   function automatic logic strb_is_aligned(logic [strb_w-1:0] strb);
      logic [3:0]  len;
      logic [2:0]  off;
      logic [15:0] ones;
      len  = 4'd1 << strb_to_size(strb);
      off  = strb_to_offset(strb);
      ones = (16'd1 << len) - 16'd1;
      return (strb != '0) && (strb == (ones[strb_w-1:0] << off)) &&
             ((4'(off) & (len - 4'd1)) == 4'd0);
   endfunction

endpackage

// ==== ahb_master/ahb_xfer_split.sv ====
/*
 * AHB write splitter
 * Byte pointer that walks the set strobes of an unaligned write,
 * one byte transfer per strobe bit
 */
`timescale 1ns/10ps

module ahb_xfer_split (
   input  logic                                ahbm_clk,
   input  logic                                rst_n,
   input  logic                                load,
   input  logic                                step,
   input  logic                                write,
   input  logic [2:0]                          aligned_size,
   input  logic [ahb_bridge_pkg::strb_w-1:0]   byteen,
   input  logic [2:0]                          addr_lo,
   output logic [2:0]                          piece_offset,
   output logic [2:0]                          piece_size,
   output logic                                last_piece
);
   import ahb_bridge_pkg::*;

   logic [2:0]        ptr_q;
   logic              sparse_q;   // Byte-by-byte mode
   logic [2:0]        size_q;
   logic [strb_w-1:0] strb_q;
   logic              aligned;

   assign aligned = ~write | strb_is_aligned(byteen);

   always_ff @(posedge ahbm_clk) begin
      if (!rst_n) begin
         ptr_q    <= 3'd0;
         sparse_q <= 1'b0;
      end else if (load) begin
         sparse_q <= ~aligned;
         ptr_q    <= write ? strb_to_offset(byteen) : addr_lo;   // Group start or first byte
      end else if (step) begin
         ptr_q <= next_byte_ptr(strb_q, ptr_q + 3'd1);
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (load) begin
         strb_q <= byteen;
         size_q <= write ? strb_to_size(byteen) : aligned_size;
      end
   end

   assign piece_offset = ptr_q;
   assign piece_size   = sparse_q ? size_byte : size_q;

   // Nothing set above the pointer
   assign last_piece = ~sparse_q | (((strb_q >> ptr_q) >> 1) == '0);

endmodule

// ==== ahb_master/ahb_master_fsm.sv ====
/*
 * AHB-Lite master FSM
 * Runs one command as one or more sequential NONSEQ transfers
 * and hands back a single response
 */
`timescale 1ns/10ps

module ahb_master_fsm #(
   parameter int ID_W = 4
) (
   input  logic                              ahbm_clk,
   input  logic                              rst_n,
   input  logic                              cmd_valid,
   output logic                              cmd_ready,
   input  ahb_bridge_pkg::bridge_cmd_t       cmd,
   output ahb_bridge_pkg::ahb_req_t          ahb_req,
   output logic [ahb_bridge_pkg::data_w-1:0] hwdata,
   input  logic [ahb_bridge_pkg::data_w-1:0] hrdata,
   input  logic                              hready,
   input  logic                              hresp,
   output logic                              rsp_valid,
   input  logic                              rsp_ready,
   output ahb_bridge_pkg::bridge_rsp_t       rsp
);
   import ahb_bridge_pkg::*;

   typedef enum logic [1:0] {st_idle, st_cmd, st_data, st_done} state_t;

   state_t            state_q, state_d;
   bridge_cmd_t       cmd_q;
   logic              hready_q, hresp_q;
   logic [data_w-1:0] hrdata_q, rdata_q;
   logic              nonseq_q;   // NONSEQ driven last cycle
   logic              err_q;
   logic              load, step, addr_acc, data_end;
   logic [2:0]        piece_offset, piece_size;
   logic              last_piece;

   assign cmd_ready = (state_q == st_idle);
   assign load      = cmd_valid & cmd_ready;
   assign addr_acc  = (state_q == st_cmd) & hready_q & nonseq_q;
   assign data_end  = (state_q == st_data) & (hready_q | hresp_q);
   assign step      = data_end & ~hresp_q & ~last_piece;   // Error stops a split write

   ahb_xfer_split split_i (
      .ahbm_clk, .rst_n,
      .load, .step,
      .write(cmd.write),
      .aligned_size(cmd.size),
      .byteen(cmd.byteen),
      .addr_lo(cmd.addr[2:0]),
      .piece_offset, .piece_size, .last_piece
   );

   // ********************
   // State machine
   // ********************
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: if (cmd_valid) state_d = st_cmd;
         st_cmd:  if (addr_acc) state_d = st_data;
         st_data: if (data_end) state_d = step ? st_cmd : st_done;
         st_done: if (rsp_ready) state_d = st_idle;
         default: state_d = st_idle;
      endcase
   end

   always_ff @(posedge ahbm_clk) begin
      if (!rst_n) begin
         state_q  <= st_idle;
         nonseq_q <= 1'b0;
         hready_q <= 1'b0;
         hresp_q  <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         state_q  <= state_d;
         nonseq_q <= (ahb_req.htrans == htrans_nonseq);
         hready_q <= hready;
         hresp_q  <= hresp;
         if (load)          err_q <= 1'b0;
         else if (data_end) err_q <= hresp_q;
      end
   end

   always_ff @(posedge ahbm_clk) begin
      hrdata_q <= hrdata;
      if (load) cmd_q <= cmd;
      if (data_end && !cmd_q.write) rdata_q <= hrdata_q;
   end

   // ********************
   // Bus and response
   // ********************
   always_comb begin
      ahb_req.haddr  = {cmd_q.addr[addr_w-1:3], piece_offset};
      ahb_req.hsize  = piece_size;
      ahb_req.htrans = (state_q == st_cmd && !addr_acc) ? htrans_nonseq : htrans_idle;
      ahb_req.hwrite = cmd_q.write;
      ahb_req.hprot  = {2'b00, cmd_q.prot[0], ~cmd_q.prot[2]};   // Privileged, data
   end

   assign hwdata = cmd_q.wdata;   // Same word for every piece

   assign rsp_valid = (state_q == st_done);
   assign rsp.tag   = 8'(cmd_q.tag[ID_W-1:0]);
   assign rsp.write = cmd_q.write;
   assign rsp.error = err_q;
   assign rsp.rdata = rdata_q;

   assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      (ahb_req.htrans == htrans_nonseq) |->
         ((4'(ahb_req.haddr[2:0]) & ((4'd1 << ahb_req.hsize) - 4'd1)) == 4'd0));

   // Two-cycle error response from the slave
   assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      (hready && hresp) |-> ($past(hresp) && !$past(hready)));

endmodule

// ==== hdl/axi_cmd_buffer.sv ====
/*
 * AXI command buffer
 * One-entry write buffer for AW and W, offered to the AHB master
 * ahead of any waiting read
 */
`timescale 1ns/10ps

module axi_cmd_buffer #(
   parameter int ID_W = 4
) (
   input  logic                        ahbm_clk,
   input  logic                        rst_n,
   input  logic                        awvalid,
   output logic                        awready,
   input  ahb_bridge_pkg::axi_aw_t     aw,
   input  logic                        wvalid,
   output logic                        wready,
   input  ahb_bridge_pkg::axi_w_t      w,
   input  logic                        arvalid,
   output logic                        arready,
   input  ahb_bridge_pkg::axi_aw_t     ar,
   output logic                        cmd_valid,
   input  logic                        cmd_ready,
   output ahb_bridge_pkg::bridge_cmd_t cmd
);
   import ahb_bridge_pkg::*;

   axi_aw_t aw_q;
   axi_w_t  w_q;
   logic    aw_vld_q, w_vld_q;
   logic    wr_offer, wr_take;

   assign wr_offer = aw_vld_q & w_vld_q;   // Write complete
   assign wr_take  = wr_offer & cmd_ready;

   assign awready   = ~aw_vld_q | wr_take;
   assign wready    = ~w_vld_q | wr_take;
   assign arready   = cmd_ready & ~wr_offer;
   assign cmd_valid = wr_offer | arvalid;

   always_comb begin
      cmd = '0;
      if (wr_offer) begin
         cmd.tag    = 8'(aw_q.id[ID_W-1:0]);
         cmd.write  = 1'b1;
         cmd.addr   = aw_q.addr;
         cmd.size   = aw_q.size;
         cmd.prot   = aw_q.prot;
         cmd.byteen = w_q.strb;
         cmd.wdata  = w_q.data;
      end else begin
         cmd.tag  = 8'(ar.id[ID_W-1:0]);   // Live AR, no buffering
         cmd.addr = ar.addr;
         cmd.size = ar.size;
         cmd.prot = ar.prot;
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (!rst_n) begin
         aw_vld_q <= 1'b0;
         w_vld_q  <= 1'b0;
      end else begin
         if (awvalid && awready) aw_vld_q <= 1'b1;
         else if (wr_take)       aw_vld_q <= 1'b0;
         if (wvalid && wready)   w_vld_q  <= 1'b1;
         else if (wr_take)       w_vld_q  <= 1'b0;
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (awvalid && awready) aw_q <= aw;
      if (wvalid && wready)   w_q  <= w;
   end

   // Handed-over write carries at least one strobe
   assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      (cmd_valid && cmd_ready && cmd.write) |-> (cmd.byteen != '0));

endmodule

// ==== hdl/axi_resp_unit.sv ====
/*
 * AXI response unit
 * Holds one finished command and returns it on B or R,
 * with the failing bus address as read data on errors
 */
`timescale 1ns/10ps

module axi_resp_unit #(
   parameter int ID_W = 4
) (
   input  logic                              ahbm_clk,
   input  logic                              rst_n,
   input  logic                              rsp_valid,
   output logic                              rsp_ready,
   input  ahb_bridge_pkg::bridge_rsp_t       rsp,
   input  ahb_bridge_pkg::ahb_req_t          ahb_req,
   input  logic                              hready,
   output logic                              bvalid,
   input  logic                              bready,
   output logic [ID_W-1:0]                   bid,
   output logic [1:0]                        bresp,
   output logic                              rvalid,
   input  logic                              rready,
   output logic [ID_W-1:0]                   rid,
   output logic [ahb_bridge_pkg::data_w-1:0] rdata,
   output logic [1:0]                        rresp
);
   import ahb_bridge_pkg::*;

   bridge_rsp_t       rsp_q;
   logic              rsp_vld_q;
   logic [addr_w-1:0] last_addr_q;

   assign rsp_ready = ~rsp_vld_q;

   always_ff @(posedge ahbm_clk) begin
      if (!rst_n)                                        rsp_vld_q <= 1'b0;
      else if (rsp_valid && rsp_ready)                   rsp_vld_q <= 1'b1;
      else if ((bvalid && bready) || (rvalid && rready)) rsp_vld_q <= 1'b0;
   end

   always_ff @(posedge ahbm_clk) begin
      if (rsp_valid && rsp_ready) rsp_q <= rsp;
      if (ahb_req.htrans == htrans_nonseq && hready) last_addr_q <= ahb_req.haddr;
   end

   // ********************
   // B and R channels
   // ********************
   assign bvalid = rsp_vld_q & rsp_q.write;
   assign bid    = rsp_q.tag[ID_W-1:0];
   assign bresp  = rsp_q.error ? resp_slverr : resp_okay;

   assign rvalid = rsp_vld_q & ~rsp_q.write;
   assign rid    = rsp_q.tag[ID_W-1:0];
   assign rresp  = rsp_q.error ? resp_slverr : resp_okay;
   assign rdata  = rsp_q.error ? {2{last_addr_q}} : rsp_q.rdata;   // Failed address twice

endmodule

// ==== hdl/axi_ahb_bridge.sv ====
/*
 * AXI4 to AHB-Lite bridge top
 * Single-beat AXI reads and writes turned into strictly
 * sequential AHB-Lite transfers
 */
`timescale 1ns/10ps

module axi_ahb_bridge #(
   parameter int ID_W = 4
) (
   input  logic                                ahbm_clk,
   input  logic                                rst_n,
   // AXI write address and data
   input  logic                                awvalid,
   output logic                                awready,
   input  ahb_bridge_pkg::axi_aw_t             aw,
   input  logic                                wvalid,
   output logic                                wready,
   input  ahb_bridge_pkg::axi_w_t              w,
   // AXI read address
   input  logic                                arvalid,
   output logic                                arready,
   input  ahb_bridge_pkg::axi_aw_t             ar,
   // AXI responses
   output logic                                bvalid,
   input  logic                                bready,
   output logic [ID_W-1:0]                     bid,
   output logic [1:0]                          bresp,
   output logic                                rvalid,
   input  logic                                rready,
   output logic [ID_W-1:0]                     rid,
   output logic [ahb_bridge_pkg::data_w-1:0]   rdata,
   output logic [1:0]                          rresp,
   // AHB-Lite master
   output ahb_bridge_pkg::ahb_req_t            ahb_req,
   output logic [ahb_bridge_pkg::data_w-1:0]   hwdata,
   input  logic [ahb_bridge_pkg::data_w-1:0]   hrdata,
   input  logic                                hready,
   input  logic                                hresp
);
   import ahb_bridge_pkg::*;

   axi_aw_t     aw_m, ar_m;   // IDs cut to ID_W
   logic        cmd_valid, cmd_ready;
   bridge_cmd_t cmd;
   logic        rsp_valid, rsp_ready;
   bridge_rsp_t rsp;

   assign aw_m = '{id: 8'(aw.id[ID_W-1:0]), addr: aw.addr, size: aw.size, prot: aw.prot};
   assign ar_m = '{id: 8'(ar.id[ID_W-1:0]), addr: ar.addr, size: ar.size, prot: ar.prot};

   axi_cmd_buffer #(.ID_W(ID_W)) cmd_buf_i (
      .ahbm_clk, .rst_n,
      .awvalid, .awready, .aw(aw_m),
      .wvalid, .wready, .w,
      .arvalid, .arready, .ar(ar_m),
      .cmd_valid, .cmd_ready, .cmd
   );

   ahb_master_fsm #(.ID_W(ID_W)) master_i (
      .ahbm_clk, .rst_n,
      .cmd_valid, .cmd_ready, .cmd,
      .ahb_req, .hwdata, .hrdata, .hready, .hresp,
      .rsp_valid, .rsp_ready, .rsp
   );

   axi_resp_unit #(.ID_W(ID_W)) resp_i (
      .ahbm_clk, .rst_n,
      .rsp_valid, .rsp_ready, .rsp,
      .ahb_req, .hready,
      .bvalid, .bready, .bid, .bresp,
      .rvalid, .rready, .rid, .rdata, .rresp
   );

endmodule

// ==== test/ahb_slave_model.sv ====
/*
 * AHB-Lite slave model
 * Byte memory with an address-based fill pattern, random wait
 * states and a two-cycle error response in a top address window
 */
`timescale 1ns/10ps

module ahb_slave_model #(
   parameter int unsigned SEED     = 1,
   parameter logic [63:0] FILL_PAT = '0,
   parameter logic [31:0] ERR_BASE = 32'hffff_0000
) (
   input  logic                              ahbm_clk,
   input  logic                              rst_n,
   input  ahb_bridge_pkg::ahb_req_t          ahb_req,
   input  logic [ahb_bridge_pkg::data_w-1:0] hwdata,
   output logic [ahb_bridge_pkg::data_w-1:0] hrdata,
   output logic                              hready,
   output logic                              hresp
);
   import ahb_bridge_pkg::*;

   typedef enum logic [1:0] {ph_idle, ph_data, ph_err1, ph_err2} phase_t;

   logic [7:0] mem [logic [addr_w-1:0]];   // Written bytes only
   logic [1:0] wait_tbl [0:255];
   logic [7:0] xfer_num;
   logic [1:0] wait_cnt;
   phase_t     phase;
   ahb_req_t   req_q;

   // Unwritten bytes come from the doubleword address
   function automatic logic [data_w-1:0] read_dword(logic [addr_w-1:0] addr);
      logic [addr_w-1:0] base;
      logic [addr_w-1:0] a;
      logic [data_w-1:0] val;
      base = {addr[addr_w-1:3], 3'b000};
      val  = {2{base}} ^ FILL_PAT;
      for (int k = 0; k < strb_w; k++) begin
         a = base + addr_w'(k);
         if (mem.exists(a)) val[8*k +: 8] = mem[a];
      end
      return val;
   endfunction

   task automatic store_lanes();
      int lo;
      int len;
      lo  = int'(req_q.haddr[2:0]);
      len = 1 << req_q.hsize;
      for (int k = lo; k < lo + len; k++) begin
         mem[{req_q.haddr[addr_w-1:3], 3'(k)}] = hwdata[8*k +: 8];
      end
   endtask

   initial begin
      void'($urandom(SEED));
      for (int i = 0; i < 256; i++) begin
         wait_tbl[i] = 2'($urandom_range(3, 0));
      end
   end

   always @(posedge ahbm_clk) begin
      if (!rst_n) begin
         phase    <= ph_idle;
         hready   <= 1'b1;
         hresp    <= 1'b0;
         xfer_num <= '0;
      end else begin
         case (phase)
            ph_idle: if (ahb_req.htrans == htrans_nonseq && hready) begin
               req_q    <= ahb_req;
               hrdata   <= read_dword(ahb_req.haddr);
               xfer_num <= xfer_num + 8'd1;
               if (ahb_req.haddr >= ERR_BASE) begin
                  phase  <= ph_err1;   // First error cycle, hready low
                  hready <= 1'b0;
                  hresp  <= 1'b1;
               end else begin
                  phase    <= ph_data;
                  wait_cnt <= wait_tbl[xfer_num];
                  hready   <= (wait_tbl[xfer_num] == 2'd0);
               end
            end
            ph_data: if (wait_cnt == 2'd0) begin
               phase <= ph_idle;
               if (req_q.hwrite) store_lanes();
            end else begin
               wait_cnt <= wait_cnt - 2'd1;
               hready   <= (wait_cnt == 2'd1);
            end
            ph_err1: begin
               phase  <= ph_err2;
               hready <= 1'b1;
            end
            default: begin
               phase <= ph_idle;
               hresp <= 1'b0;
            end
         endcase
      end
   end

endmodule

// ==== test/tb_axi_ahb_bridge.sv ====
/*
 * AXI4 to AHB-Lite bridge testbench
 * Drives single-beat writes and reads, checks the AHB transfers
 * and the B and R responses against expected tables
 */
`timescale 1ns/10ps

module tb_axi_ahb_bridge;
   import ahb_bridge_pkg::*;

   localparam int          id_w       = 4;
   localparam int          num_tests  = 6;
   localparam time         clk_period = 100ns;
   localparam int unsigned seed       = 83917;
   localparam logic [63:0] fill_pat   = 64'h5a3c_96e1_0f0f_c3a5;
   localparam logic [31:0] err_base   = 32'hffff_0000;

   typedef struct packed {
      logic [addr_w-1:0] haddr;
      logic [2:0]        hsize;
      logic              hwrite;
      logic [3:0]        hprot;
      logic [data_w-1:0] hwdata;
   } xfer_exp_t;

   typedef struct packed {
      logic              write;
      logic [id_w-1:0]   id;
      logic [1:0]        resp;
      logic [data_w-1:0] rdata;
   } rsp_exp_t;

   logic ahbm_clk = 1'b0;
   logic rst_n;
   logic awvalid, awready, wvalid, wready, arvalid, arready;
   axi_aw_t aw, ar;
   axi_w_t  w;
   logic bvalid, bready, rvalid, rready;
   logic [id_w-1:0]   bid, rid;
   logic [1:0]        bresp, rresp;
   logic [data_w-1:0] rdata, hwdata, hrdata;
   ahb_req_t ahb_req;
   logic hready, hresp;

   xfer_exp_t xfer_tbl [0:63];
   rsp_exp_t  rsp_tbl [0:31];
   int        xfer_cnt, xfer_idx, rsp_cnt, rsp_idx, error_count;
   string     test_name;
   logic      xfer_ok, b_ok, r_ok;
   logic [2:0] axi_prot;    // AxPROT for the next commands
   logic [3:0] exp_hprot;   // HPROT those commands should produce

   always #(clk_period / 2) ahbm_clk = ~ahbm_clk;

   axi_ahb_bridge #(.ID_W(id_w)) dut_i (
      .ahbm_clk, .rst_n,
      .awvalid, .awready, .aw, .wvalid, .wready, .w,
      .arvalid, .arready, .ar,
      .bvalid, .bready, .bid, .bresp,
      .rvalid, .rready, .rid, .rdata, .rresp,
      .ahb_req, .hwdata, .hrdata, .hready, .hresp
   );

   ahb_slave_model #(.SEED(seed), .FILL_PAT(fill_pat), .ERR_BASE(err_base)) slave_i (
      .ahbm_clk, .rst_n, .ahb_req, .hwdata, .hrdata, .hready, .hresp
   );

   // ********************
   // Expected values
   // ********************
   function automatic logic [data_w-1:0] fill_value(logic [addr_w-1:0] addr);
      return {2{addr[addr_w-1:3], 3'b000}} ^ fill_pat;
   endfunction

   function automatic logic [data_w-1:0] merge_bytes(logic [data_w-1:0] old_val,
         logic [data_w-1:0] new_val, logic [strb_w-1:0] strb);
      logic [data_w-1:0] res;
      res = old_val;
      for (int k = 0; k < strb_w; k++) begin
         if (strb[k]) res[8*k +: 8] = new_val[8*k +: 8];
      end
      return res;
   endfunction

   task automatic add_xfer(logic [addr_w-1:0] addr, logic [2:0] size, logic wr,
                           logic [data_w-1:0] data);
      xfer_tbl[xfer_cnt] = '{haddr: addr, hsize: size, hwrite: wr, hprot: exp_hprot,
                             hwdata: data};
      xfer_cnt++;
   endtask

   task automatic add_rsp(logic wr, logic [id_w-1:0] id, logic [1:0] resp,
                          logic [data_w-1:0] data);
      rsp_tbl[rsp_cnt] = '{write: wr, id: id, resp: resp, rdata: data};
      rsp_cnt++;
   endtask

   task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
      error_count++;
      $display("FAIL %s: %s expected %h, actual %h", test_name, what, expected, actual);
   endtask

   // ********************
   // AXI stimulus
   // ********************
   task automatic post_write(logic [id_w-1:0] id, logic [addr_w-1:0] addr,
                             logic [strb_w-1:0] strb, logic [data_w-1:0] data);
      logic aw_go;
      logic w_go;
      @(negedge ahbm_clk);
      aw = '{id: 8'(id), addr: addr, size: size_dword, prot: axi_prot};
      w  = '{data: data, strb: strb};
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (awvalid || wvalid) begin
         aw_go = awvalid && awready;   // Beat moves at the next rising edge
         w_go  = wvalid && wready;
         @(negedge ahbm_clk);
         if (aw_go) awvalid = 1'b0;
         if (w_go) wvalid = 1'b0;
      end
   endtask

   task automatic post_read(logic [id_w-1:0] id, logic [addr_w-1:0] addr);
      @(negedge ahbm_clk);
      ar = '{id: 8'(id), addr: addr, size: size_dword, prot: axi_prot};
      arvalid = 1'b1;
      while (!arready) @(negedge ahbm_clk);
      @(negedge ahbm_clk);
      arvalid = 1'b0;
   endtask

   task automatic await_responses();
      while (rsp_idx != rsp_cnt) @(negedge ahbm_clk);
      xfer_count_chk: assert (xfer_idx == xfer_cnt)
         else report_mismatch("transfer count", 64'(xfer_cnt), 64'(xfer_idx));
   endtask

   // ********************
   // Checks
   // ********************
   assign xfer_ok = (ahb_req.htrans == htrans_nonseq) && hready && (xfer_idx < xfer_cnt);
   assign b_ok    = bvalid && bready && (rsp_idx < rsp_cnt);
   assign r_ok    = rvalid && rready && (rsp_idx < rsp_cnt);

   always @(posedge ahbm_clk) begin
      if (!rst_n) begin
         xfer_idx <= 0;
         rsp_idx  <= 0;
      end else begin
         if ((ahb_req.htrans == htrans_nonseq) && hready) xfer_idx <= xfer_idx + 1;
         if ((bvalid && bready) || (rvalid && rready)) rsp_idx <= rsp_idx + 1;
      end
   end

   extra_xfer: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      ((ahb_req.htrans == htrans_nonseq) && hready) |-> (xfer_idx < xfer_cnt))
      else begin
         error_count++;
         $display("%s: unexpected AHB transfer at %h", test_name, $sampled(ahb_req.haddr));
      end
   haddr_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      xfer_ok |-> ahb_req.haddr == xfer_tbl[xfer_idx].haddr)
      else report_mismatch("haddr", xfer_tbl[$sampled(xfer_idx)].haddr, $sampled(ahb_req.haddr));
   hsize_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      xfer_ok |-> ahb_req.hsize == xfer_tbl[xfer_idx].hsize)
      else report_mismatch("hsize", xfer_tbl[$sampled(xfer_idx)].hsize, $sampled(ahb_req.hsize));
   hwrite_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      xfer_ok |-> ahb_req.hwrite == xfer_tbl[xfer_idx].hwrite)
      else report_mismatch("hwrite", xfer_tbl[$sampled(xfer_idx)].hwrite,
                           $sampled(ahb_req.hwrite));
   hprot_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      xfer_ok |-> ahb_req.hprot == xfer_tbl[xfer_idx].hprot)
      else report_mismatch("hprot", xfer_tbl[$sampled(xfer_idx)].hprot,
                           $sampled(ahb_req.hprot));
   hwdata_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      (xfer_ok && ahb_req.hwrite) |-> hwdata == xfer_tbl[xfer_idx].hwdata)
      else report_mismatch("hwdata", xfer_tbl[$sampled(xfer_idx)].hwdata, $sampled(hwdata));

   extra_rsp: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      ((bvalid && bready) || (rvalid && rready)) |-> (rsp_idx < rsp_cnt))
      else begin
         error_count++;
         $display("%s: response arrived with no command waiting for it", test_name);
      end
   b_chan_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      b_ok |-> rsp_tbl[rsp_idx].write)
      else begin
         error_count++;
         $display("%s: write response where a read response was due", test_name);
      end
   r_chan_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      r_ok |-> !rsp_tbl[rsp_idx].write)
      else begin
         error_count++;
         $display("%s: read response where a write response was due", test_name);
      end
   bid_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      b_ok |-> bid == rsp_tbl[rsp_idx].id)
      else report_mismatch("bid", rsp_tbl[$sampled(rsp_idx)].id, $sampled(bid));
   bresp_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      b_ok |-> bresp == rsp_tbl[rsp_idx].resp)
      else report_mismatch("bresp", rsp_tbl[$sampled(rsp_idx)].resp, $sampled(bresp));
   rid_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      r_ok |-> rid == rsp_tbl[rsp_idx].id)
      else report_mismatch("rid", rsp_tbl[$sampled(rsp_idx)].id, $sampled(rid));
   rresp_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      r_ok |-> rresp == rsp_tbl[rsp_idx].resp)
      else report_mismatch("rresp", rsp_tbl[$sampled(rsp_idx)].resp, $sampled(rresp));
   rdata_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      r_ok |-> rdata == rsp_tbl[rsp_idx].rdata)
      else report_mismatch("rdata", rsp_tbl[$sampled(rsp_idx)].rdata, $sampled(rdata));

   // Held B response under back-pressure
   b_hold_chk: assert property (@(posedge ahbm_clk) disable iff (!rst_n)
      (bvalid && !bready) |=> (bvalid && $stable(bid)))
      else begin
         error_count++;
         $display("%s: bvalid dropped or bid changed while bready was low", test_name);
      end

   // ********************
   // Test sequence
   // ********************
   initial begin
      rst_n       = 1'b0;
      awvalid     = 1'b0;
      wvalid      = 1'b0;
      arvalid     = 1'b0;
      aw          = '0;
      w           = '0;
      ar          = '0;
      bready      = 1'b1;
      rready      = 1'b1;
      xfer_cnt    = 0;
      rsp_cnt     = 0;
      error_count = 0;
      axi_prot    = 3'b000;
      exp_hprot   = 4'b0001;   // User data access
      test_name   = "reset";
      repeat (8) @(negedge ahbm_clk);
      rst_n = 1'b1;

      test_name = "full_dword_write";
      add_xfer(32'h0000_1000, size_dword, 1'b1, 64'h0123_4567_89ab_cdef);
      add_rsp(1'b1, 4'd3, resp_okay, '0);
      post_write(4'd3, 32'h0000_1000, 8'hff, 64'h0123_4567_89ab_cdef);
      await_responses();

      test_name = "aligned_partial_write";
      add_xfer(32'h0000_2004, size_word, 1'b1, 64'h1111_2222_3333_4444);
      add_rsp(1'b1, 4'd4, resp_okay, '0);
      post_write(4'd4, 32'h0000_2000, 8'hf0, 64'h1111_2222_3333_4444);
      await_responses();
      add_xfer(32'h0000_200a, size_half, 1'b1, 64'h5555_6666_7777_8888);
      add_rsp(1'b1, 4'd5, resp_okay, '0);
      post_write(4'd5, 32'h0000_2008, 8'h0c, 64'h5555_6666_7777_8888);
      await_responses();

      test_name = "sparse_write";   // One byte per strobe bit, ascending
      add_xfer(32'h0000_3001, size_byte, 1'b1, 64'hfedc_ba98_7654_3210);
      add_xfer(32'h0000_3003, size_byte, 1'b1, 64'hfedc_ba98_7654_3210);
      add_xfer(32'h0000_3004, size_byte, 1'b1, 64'hfedc_ba98_7654_3210);
      add_xfer(32'h0000_3006, size_byte, 1'b1, 64'hfedc_ba98_7654_3210);
      add_rsp(1'b1, 4'd6, resp_okay, '0);
      post_write(4'd6, 32'h0000_3000, 8'h5a, 64'hfedc_ba98_7654_3210);
      await_responses();
      add_xfer(32'h0000_3000, size_dword, 1'b0, '0);
      add_rsp(1'b0, 4'd7, resp_okay,
              merge_bytes(fill_value(32'h0000_3000), 64'hfedc_ba98_7654_3210, 8'h5a));
      post_read(4'd7, 32'h0000_3000);
      await_responses();

      test_name = "read";
      axi_prot  = 3'b101;
      exp_hprot = 4'b0010;   // Privileged opcode fetch
      add_xfer(32'h0000_4000, size_dword, 1'b0, '0);
      add_rsp(1'b0, 4'd8, resp_okay, fill_value(32'h0000_4000));
      post_read(4'd8, 32'h0000_4000);
      await_responses();

      test_name = "error";
      axi_prot  = 3'b000;
      exp_hprot = 4'b0001;
      add_xfer(32'hffff_0100, size_dword, 1'b1, 64'hdead_beef_cafe_f00d);
      add_rsp(1'b1, 4'd9, resp_slverr, '0);
      post_write(4'd9, 32'hffff_0100, 8'hff, 64'hdead_beef_cafe_f00d);
      await_responses();
      add_xfer(32'hffff_0208, size_dword, 1'b0, '0);
      add_rsp(1'b0, 4'd10, resp_slverr, {2{32'hffff_0208}});   // Failed address twice
      post_read(4'd10, 32'hffff_0208);
      await_responses();

      test_name = "back_pressure";
      axi_prot  = 3'b001;
      exp_hprot = 4'b0011;   // Privileged data access
      bready = 1'b0;
      add_xfer(32'h0000_6000, size_dword, 1'b1, 64'haaaa_0000_bbbb_1111);
      add_rsp(1'b1, 4'd11, resp_okay, '0);
      add_xfer(32'h0000_6008, size_dword, 1'b1, 64'hcccc_2222_dddd_3333);
      add_rsp(1'b1, 4'd12, resp_okay, '0);
      post_write(4'd11, 32'h0000_6000, 8'hff, 64'haaaa_0000_bbbb_1111);
      while (!bvalid) @(negedge ahbm_clk);
      post_write(4'd12, 32'h0000_6008, 8'hff, 64'hcccc_2222_dddd_3333);
      while (xfer_idx != xfer_cnt) @(negedge ahbm_clk);
      repeat (4) @(negedge ahbm_clk);   // Second write parked behind the first
      bready = 1'b1;
      await_responses();

      $display("Run complete: %0d transfers, %0d responses, %0d errors",
               xfer_idx, rsp_idx, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog, 200 cycles per test
   initial begin
      #(num_tests * 200 * clk_period);
      $display("Timeout: tests did not finish within %0d cycles, %0d errors so far",
               num_tests * 200, error_count);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== files.f ====
common/ahb_bridge_pkg.sv
ahb_master/ahb_xfer_split.sv
ahb_master/ahb_master_fsm.sv
hdl/axi_cmd_buffer.sv
hdl/axi_resp_unit.sv
hdl/axi_ahb_bridge.sv
test/ahb_slave_model.sv
test/tb_axi_ahb_bridge.sv
